//--- dct8_top.f
src/dct8_pkg.sv
src/dct8_sequencer.sv
src/dct8_scratchpad.sv
src/dct8_datapath.sv
src/dct8_top.sv
test/dct8_assertions.sv
test/dct8_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the DCT engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module dct8_tb -f dct8_top.f -o dct8_sim

./obj_dir/dct8_sim | tee sim.log

if grep -q "Finished with no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- src/dct8_datapath.sv
// ######################################################################
// dct8_datapath
// Operand bus select, pipelined constant multiplier, operand latch
// and the negating adder that produces the write data.
// ######################################################################
`timescale 1ns/1ps
`default_nettype none

module dct8_datapath
    import dct8_pkg::*;
#(
    parameter int DATA_WIDTH = WORD_WIDTH
) (
    input  wire                     clock,
    input  wire                     nreset,
    input  wire [SAMPLE_WIDTH-1:0]  fetch_data,
    input  wire [DATA_WIDTH-1:0]    spad_rdata,
    input  read_src_e               read_src,
    input  wire                     latch_en,
    input  operand_src_e            latch_src,
    input  wire                     negate_a,
    input  wire                     negate_b,
    input  operand_src_e            operand_b_src,
    input  coeff_e                  coeff,
    input  write_src_e              write_src,
    output logic [DATA_WIDTH-1:0]   write_data
);

    localparam int PROD_WIDTH = DATA_WIDTH + COEFF_WIDTH + 1;

    logic signed [DATA_WIDTH-1:0] operand_bus;
    logic signed [PROD_WIDTH-1:0] mul_a;
    logic signed [PROD_WIDTH-1:0] mul_b;
    logic signed [PROD_WIDTH-1:0] product;
    logic [DATA_WIDTH-1:0]        mul_pipe [MUL_LATENCY];
    logic [DATA_WIDTH-1:0]        mul_out;
    logic [DATA_WIDTH-1:0]        operand_a;
    logic [DATA_WIDTH-1:0]        operand_b;
    logic [DATA_WIDTH-1:0]        sum;

    // samples are signed, sign-extend into the word
    assign operand_bus = (read_src == READ_SPAD) ? spad_rdata
                       : {{(DATA_WIDTH-SAMPLE_WIDTH){fetch_data[SAMPLE_WIDTH-1]}}, fetch_data};

    assign mul_a   = PROD_WIDTH'(operand_bus);
    assign mul_b   = $signed(PROD_WIDTH'({1'b0, coeff_value(coeff)}));
    assign product = mul_a * mul_b;

    // only the 7q8 slice travels down the pipe
    always_ff @(posedge clock) begin
        mul_pipe[0] <= product[DATA_WIDTH+7:8];
        for (int i = 1; i < MUL_LATENCY; i++) begin
            mul_pipe[i] <= mul_pipe[i-1];
        end
    end

    assign mul_out = mul_pipe[MUL_LATENCY-1];

    always_ff @(posedge clock) begin
        if (nreset) begin
            operand_a <= '0;
        end else if (latch_en) begin
            operand_a <= (latch_src == OP_MUL) ? mul_out : operand_bus;
        end
    end

    assign operand_b = (operand_b_src == OP_MUL) ? mul_out : operand_bus;

    always_comb begin
        sum = (negate_a ? -operand_a : operand_a) + (negate_b ? -operand_b : operand_b);
        write_data = (write_src == WSRC_MUL) ? mul_out : sum;   // wraps at word width
    end

endmodule

`default_nettype wire

//--- src/dct8_pkg.sv
// ######################################################################
// dct8_pkg
// Shared widths, 7q8 coefficients and control encodings for the
// 8-point Loeffler DCT engine.
// ######################################################################
`default_nettype none

package dct8_pkg;

    localparam int SAMPLE_WIDTH     = 8;   // signed input sample
    localparam int WORD_WIDTH       = 16;  // 7q8 word
    localparam int SPAD_ADDR_WIDTH  = 5;
    localparam int FETCH_ADDR_WIDTH = 3;
    localparam int COEFF_WIDTH      = 9;   // unsigned coefficient
    localparam int UCODE_LEN        = 57;
    localparam int MUL_LATENCY      = 2;   // microcode schedule depends on this

    // the eight flowgraph constants, scaled into 7q8
    typedef enum logic [2:0] {
        C3_COS        = 3'd0,
        C3_SIN        = 3'd1,
        C1_COS        = 3'd2,
        C1_SIN        = 3'd3,
        R2C6_COS      = 3'd4,
        R2C6_SIN      = 3'd5,
        SQRT2         = 3'd6,
        SQRT2_QUARTER = 3'd7
    } coeff_e;

    typedef enum logic {READ_FETCH, READ_SPAD} read_src_e;
    typedef enum logic {OP_MEM, OP_MUL} operand_src_e;
    typedef enum logic [1:0] {DEST_NONE, DEST_SPAD, DEST_RESULT} write_dest_e;
    typedef enum logic {WSRC_ADDER, WSRC_MUL} write_src_e;
    typedef enum logic {ST_IDLE, ST_RUN} seq_state_e;

    function automatic logic [COEFF_WIDTH-1:0] coeff_value(input coeff_e sel);
        case (sel)
            C3_COS:        return 9'd75;   // cos(3pi/16) / (2 sqrt 2)
            C3_SIN:        return 9'd50;
            C1_COS:        return 9'd89;
            C1_SIN:        return 9'd18;
            R2C6_COS:      return 9'd49;   // sqrt2 cos(6pi/16) / (2 sqrt 2)
            R2C6_SIN:      return 9'd118;
            SQRT2:         return 9'd362;
            default:       return 9'd90;   // sqrt2 / 4
        endcase
    endfunction

endpackage

`default_nettype wire

//--- src/dct8_scratchpad.sv
// ######################################################################
// dct8_scratchpad
// 32-entry intermediate store, one write port, registered read port.
// ######################################################################
`timescale 1ns/1ps
`default_nettype none

module dct8_scratchpad
    import dct8_pkg::*;
#(
    parameter int DATA_WIDTH = WORD_WIDTH
) (
    input  wire                        clock,
    input  wire                        wren,
    input  wire [SPAD_ADDR_WIDTH-1:0]  waddr,
    input  wire [SPAD_ADDR_WIDTH-1:0]  raddr,
    input  wire [DATA_WIDTH-1:0]       wdata,
    output logic [DATA_WIDTH-1:0]      rdata
);

    logic [DATA_WIDTH-1:0] mem [2**SPAD_ADDR_WIDTH];

    always_ff @(posedge clock) begin
        if (wren) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];   // one-cycle read latency
    end

endmodule

`default_nettype wire

//--- src/dct8_sequencer.sv
// ######################################################################
// dct8_sequencer
// Start/busy/done control, microcode program counter and the 57-step
// control ROM that schedules the DCT flowgraph onto the datapath.
// ######################################################################
`timescale 1ns/1ps
`default_nettype none

module dct8_sequencer
    import dct8_pkg::*;
(
    input  wire                          clock,
    input  wire                          nreset,
    input  wire                          start,
    output logic                         busy,
    output logic                         done,
    output logic [FETCH_ADDR_WIDTH-1:0]  fetch_addr,
    output logic [SPAD_ADDR_WIDTH-1:0]   spad_raddr,
    output logic [SPAD_ADDR_WIDTH-1:0]   spad_waddr,
    output logic                         spad_wren,
    output logic                         result_wren,
    output logic [FETCH_ADDR_WIDTH-1:0]  result_addr,
    output read_src_e                    read_src,
    output logic                         latch_en,
    output operand_src_e                 latch_src,
    output logic                         negate_a,
    output logic                         negate_b,
    output operand_src_e                 operand_b_src,
    output coeff_e                       coeff,
    output write_src_e                   write_src
);

    localparam int PC_WIDTH = $clog2(UCODE_LEN);
    localparam logic [PC_WIDTH-1:0] LAST_PC = PC_WIDTH'(UCODE_LEN - 1);

    // flags = {read_src, latch_en, latch_src, negate_a, negate_b, operand_b_src}
    typedef struct packed {
        logic [SPAD_ADDR_WIDTH-1:0] raddr;
        logic [5:0]                 flags;
        coeff_e                     coeff;
        logic [SPAD_ADDR_WIDTH-1:0] waddr;
        write_dest_e                dest;
        write_src_e                 wsrc;
    } ctrl_t;

    seq_state_e          state;
    logic [PC_WIDTH-1:0] pc;
    ctrl_t               ctl;

    function automatic ctrl_t step(input logic [4:0] ra, input logic [5:0] fl,
                                   input coeff_e cf, input logic [4:0] wa,
                                   input write_dest_e wd, input write_src_e ws);
        return '{ra, fl, cf, wa, wd, ws};
    endfunction

    always_ff @(posedge clock) begin
        if (nreset) begin
            state <= ST_IDLE;
            pc    <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: if (start) begin
                    state <= ST_RUN;
                    pc    <= '0;
                end
                default: if (pc == LAST_PC) begin
                    state <= ST_IDLE;   // done and busy fall together
                    done  <= 1'b1;
                    pc    <= '0;
                end else begin
                    pc <= pc + 1'b1;
                end
            endcase
        end
    end

    assign busy = (state == ST_RUN);

    // read data of step n is on the operand bus during step n+1
    always_comb begin
        case (pc)
            // stage 1 butterflies on samples from the fetch memory
            6'd0:  ctl = step(5'd0,  6'b010000, C3_COS, 5'd0,  DEST_NONE, WSRC_ADDER);
            6'd1:  ctl = step(5'd7,  6'b010000, C3_COS, 5'd0,  DEST_NONE, WSRC_ADDER);
            6'd2:  ctl = step(5'd1,  6'b000000, C3_COS, 5'd0,  DEST_SPAD, WSRC_ADDER);
            6'd3:  ctl = step(5'd6,  6'b010000, C3_COS, 5'd0,  DEST_NONE, WSRC_ADDER);
            6'd4:  ctl = step(5'd2,  6'b000000, C3_COS, 5'd1,  DEST_SPAD, WSRC_ADDER);
            6'd5:  ctl = step(5'd5,  6'b010000, C3_COS, 5'd0,  DEST_NONE, WSRC_ADDER);
            6'd6:  ctl = step(5'd3,  6'b000000, C3_COS, 5'd2,  DEST_SPAD, WSRC_ADDER);
            6'd7:  ctl = step(5'd4,  6'b010000, C3_COS, 5'd0,  DEST_NONE, WSRC_ADDER);
            6'd8:  ctl = step(5'd3,  6'b000000, C3_COS, 5'd3,  DEST_SPAD, WSRC_ADDER);
            6'd9:  ctl = step(5'd4,  6'b010000, C3_COS, 5'd0,  DEST_NONE, WSRC_ADDER);
            6'd10: ctl = step(5'd2,  6'b000010, C3_COS, 5'd4,  DEST_SPAD, WSRC_ADDER);
            6'd11: ctl = step(5'd5,  6'b010000, C3_COS, 5'd0,  DEST_NONE, WSRC_ADDER);
            6'd12: ctl = step(5'd1,  6'b000010, C3_COS, 5'd5,  DEST_SPAD, WSRC_ADDER);
            6'd13: ctl = step(5'd6,  6'b010000, C3_COS, 5'd0,  DEST_NONE, WSRC_ADDER);
            6'd14: ctl = step(5'd0,  6'b000010, C3_COS, 5'd6,  DEST_SPAD, WSRC_ADDER);
            6'd15: ctl = step(5'd7,  6'b010000, C3_COS, 5'd0,  DEST_NONE, WSRC_ADDER);
            6'd16: ctl = step(5'd0,  6'b000010, C3_COS, 5'd7,  DEST_SPAD, WSRC_ADDER);
            // even part adds s8..s11
            6'd17: ctl = step(5'd3,  6'b110000, C3_COS, 5'd0,  DEST_NONE, WSRC_ADDER);
            6'd18: ctl = step(5'd1,  6'b100000, C3_COS, 5'd8,  DEST_SPAD, WSRC_ADDER);
            6'd19: ctl = step(5'd2,  6'b110000, C3_COS, 5'd0,  DEST_NONE, WSRC_ADDER);
            6'd20: ctl = step(5'd1,  6'b100000, C3_COS, 5'd9,  DEST_SPAD, WSRC_ADDER);
            6'd21: ctl = step(5'd2,  6'b110000, C3_COS, 5'd0,  DEST_NONE, WSRC_ADDER);
            6'd22: ctl = step(5'd0,  6'b100010, C3_COS, 5'd10, DEST_SPAD, WSRC_ADDER);
            6'd23: ctl = step(5'd3,  6'b110000, C3_COS, 5'd0,  DEST_NONE, WSRC_ADDER);
            6'd24: ctl = step(5'd4,  6'b100010, C3_COS, 5'd11, DEST_SPAD, WSRC_ADDER);
            // odd rotations with products arriving two steps after issue
            6'd25: ctl = step(5'd7,  6'b100000, C3_COS, 5'd0,  DEST_NONE, WSRC_ADDER);
            6'd26: ctl = step(5'd4,  6'b100000, C3_SIN, 5'd0,  DEST_NONE, WSRC_ADDER);
            6'd27: ctl = step(5'd7,  6'b111000, C3_SIN, 5'd0,  DEST_NONE, WSRC_ADDER);
            6'd28: ctl = step(5'd5,  6'b100001, C3_COS, 5'd12, DEST_SPAD, WSRC_ADDER);
            6'd29: ctl = step(5'd6,  6'b111000, C1_COS, 5'd0,  DEST_NONE, WSRC_ADDER);
            6'd30: ctl = step(5'd5,  6'b100101, C1_SIN, 5'd15, DEST_SPAD, WSRC_ADDER);
            6'd31: ctl = step(5'd6,  6'b111000, C1_SIN, 5'd0,  DEST_NONE, WSRC_ADDER);
            6'd32: ctl = step(5'd8,  6'b100001, C1_COS, 5'd13, DEST_SPAD, WSRC_ADDER);
            6'd33: ctl = step(5'd9,  6'b111000, SQRT2_QUARTER, 5'd0, DEST_NONE, WSRC_ADDER);
            6'd34: ctl = step(5'd8,  6'b100101, SQRT2_QUARTER, 5'd14, DEST_SPAD, WSRC_ADDER);
            // y0, y4, y2, y6
            6'd35: ctl = step(5'd9,  6'b111000, SQRT2_QUARTER, 5'd0, DEST_NONE, WSRC_ADDER);
            6'd36: ctl = step(5'd10, 6'b100001, SQRT2_QUARTER, 5'd0, DEST_RESULT, WSRC_ADDER);
            6'd37: ctl = step(5'd11, 6'b111000, R2C6_COS, 5'd0, DEST_NONE, WSRC_ADDER);
            6'd38: ctl = step(5'd10, 6'b100011, R2C6_SIN, 5'd4, DEST_RESULT, WSRC_ADDER);
            6'd39: ctl = step(5'd11, 6'b111000, R2C6_SIN, 5'd0, DEST_NONE, WSRC_ADDER);
            6'd40: ctl = step(5'd0,  6'b100001, R2C6_COS, 5'd2, DEST_RESULT, WSRC_ADDER);
            6'd41: ctl = step(5'd12, 6'b111000, C3_COS, 5'd0,  DEST_NONE, WSRC_ADDER);
            6'd42: ctl = step(5'd14, 6'b110101, C3_COS, 5'd6,  DEST_RESULT, WSRC_ADDER);
            // odd butterflies s20..s23
            6'd43: ctl = step(5'd13, 6'b100000, C3_COS, 5'd20, DEST_SPAD, WSRC_ADDER);
            6'd44: ctl = step(5'd15, 6'b110000, C3_COS, 5'd0,  DEST_NONE, WSRC_ADDER);
            6'd45: ctl = step(5'd12, 6'b100100, C3_COS, 5'd21, DEST_SPAD, WSRC_ADDER);
            6'd46: ctl = step(5'd14, 6'b110000, C3_COS, 5'd0,  DEST_NONE, WSRC_ADDER);
            6'd47: ctl = step(5'd13, 6'b100010, C3_COS, 5'd22, DEST_SPAD, WSRC_ADDER);
            6'd48: ctl = step(5'd15, 6'b110000, C3_COS, 5'd0,  DEST_NONE, WSRC_ADDER);
            6'd49: ctl = step(5'd20, 6'b100000, C3_COS, 5'd23, DEST_SPAD, WSRC_ADDER);
            // y7, y1, then y3 and y5 straight from the multiplier
            6'd50: ctl = step(5'd23, 6'b110000, C3_COS, 5'd0,  DEST_NONE, WSRC_ADDER);
            6'd51: ctl = step(5'd23, 6'b100100, C3_COS, 5'd7,  DEST_RESULT, WSRC_ADDER);
            6'd52: ctl = step(5'd21, 6'b100000, C3_COS, 5'd1,  DEST_RESULT, WSRC_ADDER);
            6'd53: ctl = step(5'd22, 6'b100000, SQRT2,  5'd0,  DEST_NONE, WSRC_ADDER);
            6'd54: ctl = step(5'd0,  6'b100000, SQRT2,  5'd0,  DEST_NONE, WSRC_ADDER);
            6'd55: ctl = step(5'd0,  6'b100000, C3_COS, 5'd3,  DEST_RESULT, WSRC_MUL);
            6'd56: ctl = step(5'd0,  6'b100000, C3_COS, 5'd5,  DEST_RESULT, WSRC_MUL);
            default: ctl = step(5'd0, 6'b000000, C3_COS, 5'd0, DEST_NONE, WSRC_ADDER);
        endcase
    end

    assign fetch_addr    = ctl.raddr[FETCH_ADDR_WIDTH-1:0];
    assign spad_raddr    = ctl.raddr;
    assign spad_waddr    = ctl.waddr;
    assign result_addr   = ctl.waddr[FETCH_ADDR_WIDTH-1:0];
    assign spad_wren     = busy && (ctl.dest == DEST_SPAD);
    assign result_wren   = (ctl.dest == DEST_RESULT);   // idle pc rests on step 0
    assign read_src      = read_src_e'(ctl.flags[5]);
    assign latch_en      = ctl.flags[4];
    assign latch_src     = operand_src_e'(ctl.flags[3]);
    assign negate_a      = ctl.flags[2];
    assign negate_b      = ctl.flags[1];
    assign operand_b_src = operand_src_e'(ctl.flags[0]);
    assign coeff         = ctl.coeff;
    assign write_src     = ctl.wsrc;

endmodule

`default_nettype wire

//--- src/dct8_top.sv
// ######################################################################
// dct8_top
// 8-point Loeffler DCT engine. One start pulse runs the microcode
// once over the fetch memory and writes eight 7q8 coefficients.
// ######################################################################
`timescale 1ns/1ps
`default_nettype none

module dct8_top
    import dct8_pkg::*;
#(
    parameter int DATA_WIDTH = WORD_WIDTH
) (
    input  wire                          clock,
    input  wire                          nreset,
    input  wire                          start,
    output logic                         busy,
    output logic                         done,
    output logic [FETCH_ADDR_WIDTH-1:0]  fetch_addr,
    input  wire  [SAMPLE_WIDTH-1:0]      fetch_data,
    output logic                         result_wren,
    output logic [FETCH_ADDR_WIDTH-1:0]  result_addr,
    output logic [DATA_WIDTH-1:0]        result_out
);

    logic [SPAD_ADDR_WIDTH-1:0] spad_raddr;
    logic [SPAD_ADDR_WIDTH-1:0] spad_waddr;
    logic                       spad_wren;
    logic [DATA_WIDTH-1:0]      spad_rdata;
    logic [DATA_WIDTH-1:0]      write_data;
    read_src_e                  read_src;
    logic                       latch_en;
    operand_src_e               latch_src;
    logic                       negate_a;
    logic                       negate_b;
    operand_src_e               operand_b_src;
    coeff_e                     coeff;
    write_src_e                 write_src;

    dct8_sequencer u_sequencer (
        .clock         (clock),
        .nreset        (nreset),
        .start         (start),
        .busy          (busy),
        .done          (done),
        .fetch_addr    (fetch_addr),
        .spad_raddr    (spad_raddr),
        .spad_waddr    (spad_waddr),
        .spad_wren     (spad_wren),
        .result_wren   (result_wren),
        .result_addr   (result_addr),
        .read_src      (read_src),
        .latch_en      (latch_en),
        .latch_src     (latch_src),
        .negate_a      (negate_a),
        .negate_b      (negate_b),
        .operand_b_src (operand_b_src),
        .coeff         (coeff),
        .write_src     (write_src)
    );

    dct8_scratchpad #(.DATA_WIDTH(DATA_WIDTH)) u_scratchpad (
        .clock (clock),
        .wren  (spad_wren),
        .waddr (spad_waddr),
        .raddr (spad_raddr),
        .wdata (write_data),
        .rdata (spad_rdata)
    );

    dct8_datapath #(.DATA_WIDTH(DATA_WIDTH)) u_datapath (
        .clock         (clock),
        .nreset        (nreset),
        .fetch_data    (fetch_data),
        .spad_rdata    (spad_rdata),
        .read_src      (read_src),
        .latch_en      (latch_en),
        .latch_src     (latch_src),
        .negate_a      (negate_a),
        .negate_b      (negate_b),
        .operand_b_src (operand_b_src),
        .coeff         (coeff),
        .write_src     (write_src),
        .write_data    (write_data)
    );

    assign result_out = write_data;   // valid only with result_wren

endmodule

`default_nettype wire

//--- test/dct8_assertions.sv
// ######################################################################
// dct8_assertions
// Concurrent checks on the DCT engine control ports, bound into
// dct8_top.
// ######################################################################
`timescale 1ns/1ps
`default_nettype none

module dct8_assertions
    import dct8_pkg::*;
(
    input wire                         clock,
    input wire                         nreset,
    input wire                         busy,
    input wire                         done,
    input wire                         result_wren,
    input wire [FETCH_ADDR_WIDTH-1:0]  fetch_addr,
    input wire [FETCH_ADDR_WIDTH-1:0]  result_addr
);

    wren_in_frame: assert property (@(posedge clock) disable iff (nreset)
        result_wren |-> busy)
        else $error("result_wren high while idle");

    done_single: assert property (@(posedge clock) disable iff (nreset)
        done |=> !done)
        else $error("done held longer than one cycle");

    done_with_busy_fall: assert property (@(posedge clock) disable iff (nreset)
        done |-> $fell(busy))   // busy drops in the done cycle
        else $error("done not aligned with busy falling");

    addr_known: assert property (@(posedge clock) disable iff (nreset)
        busy |-> !$isunknown(fetch_addr) && !$isunknown(result_addr))
        else $error("unknown address while busy");

endmodule

bind dct8_top dct8_assertions u_assertions (
    .clock       (clock),
    .nreset      (nreset),
    .busy        (busy),
    .done        (done),
    .result_wren (result_wren),
    .fetch_addr  (fetch_addr),
    .result_addr (result_addr)
);

`default_nettype wire

//--- test/dct8_tb.sv
// ######################################################################
// dct8_tb
// Testbench for the 8-point DCT engine with LCG sample frames, a fetch
// memory with one-cycle read latency, a flowgraph reference model and
// per-frame checks of every result write.
// ######################################################################
`timescale 1ns/1ps
`default_nettype none

module dct8_tb
    import dct8_pkg::*;
;

    localparam int CLOCK_PERIOD = 40;
    localparam int RESET_CYCLES = 16;
    localparam int FRAME_BUDGET = 30;   // 28 frames plus test 1 and the long idle of test 4
    localparam int TIMEOUT_NS   = FRAME_BUDGET * (UCODE_LEN + 10) * CLOCK_PERIOD
                                + RESET_CYCLES * CLOCK_PERIOD;

    // 7q8 constants of the flowgraph
    localparam int K_C3_COS   = 75;
    localparam int K_C3_SIN   = 50;
    localparam int K_C1_COS   = 89;
    localparam int K_C1_SIN   = 18;
    localparam int K_R2C6_COS = 49;
    localparam int K_R2C6_SIN = 118;
    localparam int K_SQRT2    = 362;
    localparam int K_SQRT2_Q  = 90;

    logic                        clock;
    logic                        nreset;
    logic                        start;
    logic                        busy;
    logic                        done;
    logic [FETCH_ADDR_WIDTH-1:0] fetch_addr;
    logic [SAMPLE_WIDTH-1:0]     fetch_data;
    logic                        result_wren;
    logic [FETCH_ADDR_WIDTH-1:0] result_addr;
    logic [WORD_WIDTH-1:0]       result_out;

    logic [SAMPLE_WIDTH-1:0]     fetch_mem [8];
    logic [FETCH_ADDR_WIDTH-1:0] last_fetch_addr;
    logic [SAMPLE_WIDTH-1:0]     samples [8];    // next frame
    logic [WORD_WIDTH-1:0]       expected [8];
    logic [WORD_WIDTH-1:0]       got [8];
    int                          wr_count [8];
    int                          done_count;
    logic [31:0]                 rng_state = 32'h3a42;
    int                          errors;
    int                          checks;
    int                          tests;
    int                          errors_at_test_start;

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    dct8_top dut (
        .clock       (clock),
        .nreset      (nreset),
        .start       (start),
        .busy        (busy),
        .done        (done),
        .fetch_addr  (fetch_addr),
        .fetch_data  (fetch_data),
        .result_wren (result_wren),
        .result_addr (result_addr),
        .result_out  (result_out)
    );

    // synchronous sample memory with data one cycle after its address
    always @(negedge clock) begin
        fetch_data      <= fetch_mem[last_fetch_addr];
        last_fetch_addr <= fetch_addr;
    end

    always @(posedge clock) begin
        if (result_wren) begin
            wr_count[result_addr] = wr_count[result_addr] + 1;
            got[result_addr]      = result_out;
        end
        if (done) begin
            done_count = done_count + 1;
        end
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // 7q8 rescale keeps bits 23..8 of the signed product
    function automatic logic [WORD_WIDTH-1:0] scale_7q8(input logic [WORD_WIDTH-1:0] v,
                                                       input int c);
        logic signed [31:0] p;
        p = $signed(v) * c;
        return p[23:8];
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] want);
        checks++;
        if (actual !== want) begin
            errors++;
            $display("FAIL %s: got 0x%h expected 0x%h", name, actual, want);
        end
    endtask

    task automatic compute_model();
        logic [WORD_WIDTH-1:0] x [8];
        logic [WORD_WIDTH-1:0] s [24];
        for (int i = 0; i < 8; i++) begin
            x[i] = {{(WORD_WIDTH-SAMPLE_WIDTH){samples[i][SAMPLE_WIDTH-1]}}, samples[i]};
        end
        s[0] = x[0] + x[7];
        s[1] = x[1] + x[6];
        s[2] = x[2] + x[5];
        s[3] = x[3] + x[4];
        s[4] = x[3] - x[4];
        s[5] = x[2] - x[5];
        s[6] = x[1] - x[6];
        s[7] = x[0] - x[7];
        s[8]  = s[0] + s[3];
        s[9]  = s[1] + s[2];
        s[10] = s[1] - s[2];
        s[11] = s[0] - s[3];
        expected[0] = scale_7q8(s[8], K_SQRT2_Q) + scale_7q8(s[9], K_SQRT2_Q);
        expected[4] = scale_7q8(s[8], K_SQRT2_Q) - scale_7q8(s[9], K_SQRT2_Q);
        expected[2] = scale_7q8(s[10], K_R2C6_COS) + scale_7q8(s[11], K_R2C6_SIN);
        expected[6] = scale_7q8(s[11], K_R2C6_COS) - scale_7q8(s[10], K_R2C6_SIN);
        s[12] = scale_7q8(s[4], K_C3_COS) + scale_7q8(s[7], K_C3_SIN);
        s[15] = scale_7q8(s[7], K_C3_COS) - scale_7q8(s[4], K_C3_SIN);
        s[13] = scale_7q8(s[5], K_C1_COS) + scale_7q8(s[6], K_C1_SIN);
        s[14] = scale_7q8(s[6], K_C1_COS) - scale_7q8(s[5], K_C1_SIN);
        s[20] = s[12] + s[14];
        s[21] = s[15] - s[13];
        s[22] = s[12] - s[14];
        s[23] = s[13] + s[15];
        expected[1] = s[20] + s[23];
        expected[7] = s[23] - s[20];
        expected[3] = scale_7q8(s[21], K_SQRT2);
        expected[5] = scale_7q8(s[22], K_SQRT2);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clock);
    endtask

    task automatic begin_test();
        tests++;
        errors_at_test_start = errors;
    endtask

    task automatic end_test(input string name);
        int n;
        n = errors - errors_at_test_start;
        $display("test %0d %s: %s (%0d errors)", tests, name, (n == 0) ? "ok" : "FAILED", n);
    endtask

    // runs from a falling edge to the falling edge after done
    task automatic run_frame(input string label, input bit poke_busy);
        int waited;
        compute_model();
        for (int i = 0; i < 8; i++) begin
            fetch_mem[i] <= samples[i];
            wr_count[i] = 0;
        end
        done_count = 0;
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        if (poke_busy) begin
            idle_cycles(10);
            check_value({label, " busy"}, busy, 1);
            start = 1'b1;   // must be ignored mid-frame
            @(negedge clock);
            start = 1'b0;
        end
        waited = 0;
        while (done_count == 0 && waited < UCODE_LEN + 10) begin
            @(negedge clock);
            waited++;
        end
        if (done_count == 0) begin
            errors++;
            $display("%s: no done pulse within %0d cycles of start", label, waited);
        end else begin
            check_value({label, " done"}, done, 0);   // pulse already over
            for (int i = 0; i < 8; i++) begin
                check_value($sformatf("%s wr_count[%0d]", label, i), wr_count[i], 1);
                check_value($sformatf("%s result_out[%0d]", label, i), got[i], expected[i]);
            end
        end
    endtask

    task automatic fill_random();
        logic [31:0] r;
        for (int i = 0; i < 8; i++) begin
            r = lcg_next();
            samples[i] = r[23:16];
        end
    endtask

    initial begin
        nreset = 1'b1;
        start  = 1'b0;
        fetch_data = '0;
        last_fetch_addr = '0;
        errors = 0;
        checks = 0;
        tests  = 0;
        done_count = 0;
        for (int i = 0; i < 8; i++) begin
            fetch_mem[i] = '0;
            wr_count[i]  = 0;
            got[i]       = '0;
        end
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        nreset = 1'b0;

        begin_test();
        for (int c = 0; c < 10; c++) begin
            @(negedge clock);
            check_value("busy", busy, 0);
            check_value("done", done, 0);
            check_value("result_wren", result_wren, 0);
        end
        end_test("idle after reset");

        begin_test();
        for (int f = 0; f < 20; f++) begin
            fill_random();
            run_frame($sformatf("random %0d", f), 1'b0);
            idle_cycles(2);
        end
        end_test("random frames");

        begin_test();
        for (int i = 0; i < 8; i++) samples[i] = 8'h00;
        run_frame("zeros", 1'b0);
        idle_cycles(2);
        for (int i = 0; i < 8; i++) samples[i] = 8'h7f;
        run_frame("all +127", 1'b0);
        idle_cycles(2);
        for (int i = 0; i < 8; i++) samples[i] = 8'h80;
        run_frame("all -128", 1'b0);
        idle_cycles(2);
        for (int i = 0; i < 8; i++) samples[i] = (i % 2 == 0) ? 8'h80 : 8'h7f;
        run_frame("alternating", 1'b0);
        idle_cycles(2);
        end_test("edge frames");

        begin_test();
        fill_random();
        run_frame("start while busy", 1'b1);
        idle_cycles(UCODE_LEN + 4);   // a restarted frame would show up here
        check_value("late done pulses", done_count, 1);
        for (int i = 0; i < 8; i++) begin
            check_value($sformatf("late wr_count[%0d]", i), wr_count[i], 1);
        end
        end_test("start ignored while busy");

        begin_test();
        for (int f = 0; f < 3; f++) begin
            fill_random();
            run_frame($sformatf("back-to-back %0d", f), 1'b0);
        end
        end_test("back-to-back frames");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: run did not finish within %0d ns", TIMEOUT_NS);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire
